/* axi_read_master.f */
+incdir+rtl
rtl/axi_rd_pkg.sv
rtl/ar_issue.sv
rtl/beat_addr_gen.sv
rtl/byte_ram.sv
rtl/axi_read_master.sv
dv/axi_rd_slave_model.sv
dv/tb_axi_read_master.sv

/* dv/axi_rd_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_rd_slave_model (
	input  logic                clk,
	input  logic                resetn,
	input  axi_rd_pkg::ar_req_t ar,
	input  logic                arvalid,
	output logic                arready,
	output logic                rvalid,
	output axi_rd_pkg::r_beat_t r,
	input  logic                rready,
	output axi_rd_pkg::ar_req_t ar_seen,
	output int                  ar_count
);

	import axi_rd_pkg::*;

	logic [31:0] lfsr;
	logic        run_q;
	logic        arvalid_q;
	logic        rready_q;
	ar_req_t     ar_q;
	logic        bursting;
	int          beat;
	logic        bit_val;

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	// Lane k of beat i carries A0 + 16*id + i + k
	function automatic logic [31:0] beat_data(input logic [3:0] id, input int i);
		logic [31:0] d;
		for (int k = 0; k < 4; k++) begin
			d[8*k +: 8] = 8'hA0 + {id, 4'h0} + 8'(i) + 8'(k);
		end
		return d;
	endfunction

	initial begin
		run_q    = 1'b0;
		arready  = 1'b0;
		rvalid   = 1'b0;
		r        = '0;
		ar_seen  = '0;
		ar_count = 0;
	end

	always @(posedge clk) begin
		run_q <= resetn;
	end

	always @(negedge clk) begin
		if (!run_q) begin
			lfsr      = 32'h85cc_bc1a;
			arready   = 1'b0;
			rvalid    = 1'b0;
			bursting  = 1'b0;
			beat      = 0;
			arvalid_q = 1'b0;
			rready_q  = 1'b0;
		end else begin
			// Handshakes on the rising edge just past
			if (arvalid_q && arready) begin
				ar_seen  = ar_q;
				ar_count = ar_count + 1;
				bursting = 1'b1;
				beat     = 0;
			end
			if (rvalid && rready_q) begin
				rvalid = 1'b0;
				if (beat == int'(ar_seen.len)) begin
					bursting = 1'b0;
				end
				beat = beat + 1;
			end
			take_bit(bit_val);
			arready = bit_val;
			// A presented beat stays put until taken
			if (bursting && !rvalid) begin
				take_bit(bit_val);
				if (bit_val) begin
					rvalid = 1'b1;
					r.id   = ar_seen.id;
					r.data = beat_data(ar_seen.id, beat);
					r.last = (beat == int'(ar_seen.len));
				end
			end
			arvalid_q = arvalid;
			ar_q      = ar;
			rready_q  = rready;
		end
	end

endmodule

`default_nettype wire

/* dv/tb_axi_read_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module tb_axi_read_master;

	import axi_rd_pkg::*;

	localparam int NUM_TESTS    = 7;
	localparam int NUM_BEATS    = 29;
	localparam int RESET_CYCLES = 16;
	// Sixteen slow beats plus setup and readback for every test
	localparam int LIMIT_CYCLES = RESET_CYCLES + NUM_TESTS * (16 * 8 + 64);

	logic                   clk;
	logic                   resetn;
	logic                   start;
	ar_req_t                req;
	logic                   busy;
	logic                   done;
	ar_req_t                ar;
	logic                   arvalid;
	logic                   arready;
	logic                   rvalid;
	r_beat_t                r;
	logic                   rready;
	logic [`RAM_ADDR_W-1:0] mem_raddr;
	logic [7:0]             mem_rdata;
	ar_req_t                ar_seen;
	int                     ar_count;

	ar_req_t     req_tab  [NUM_TESTS];
	logic [11:0] beat_tab [NUM_BEATS];
	logic [7:0]  model    [`RAM_BYTES];
	int          cur_test;
	int          check_count;
	int          err_count;
	int          done_count;
	logic        watch_busy;
	logic        ar_wait_q;
	ar_req_t     ar_hold_q;

	axi_read_master UUT (.*);

	axi_rd_slave_model slave (.*);

	always #20 clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("FAIL %0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic load_table();
		// id, addr, len, size, burst
		req_tab[0] = {4'h1, 32'h0000_0000, 4'd3, 3'd0, BURST_INCR};
		req_tab[1] = {4'h2, 32'h0000_0102, 4'd3, 3'd1, BURST_INCR};
		req_tab[2] = {4'h3, 32'h0000_0204, 4'd3, 3'd2, BURST_INCR};
		req_tab[3] = {4'h4, 32'h0000_0300, 4'd2, 3'd2, BURST_FIXED};
		req_tab[4] = {4'h5, 32'h0000_0408, 4'd3, 3'd2, BURST_WRAP};
		req_tab[5] = {4'h6, 32'h0000_050c, 4'd7, 3'd1, BURST_WRAP};
		req_tab[6] = {4'h7, 32'h0000_0ffe, 4'd1, 3'd1, BURST_INCR};
		// Start address of every beat in table order
		beat_tab = '{
			12'h000, 12'h001, 12'h002, 12'h003,
			12'h102, 12'h104, 12'h106, 12'h108,
			12'h204, 12'h208, 12'h20c, 12'h210,
			12'h300, 12'h300, 12'h300,
			12'h408, 12'h40c, 12'h400, 12'h404,
			12'h50c, 12'h50e, 12'h500, 12'h502, 12'h504, 12'h506, 12'h508, 12'h50a,
			12'hffe, 12'h000
		};
	endtask

	task automatic run_test(input int t, input int bi);
		ar_req_t     entry;
		int          done_base;
		int          ar_base;
		int          err_base;
		int          nbytes;
		logic [11:0] a;
		logic [11:0] ra;

		entry     = req_tab[t];
		nbytes    = 1 << entry.size;
		done_base = done_count;
		ar_base   = ar_count;
		err_base  = err_count;
		req       = entry;
		start     = 1'b1;
		@(negedge clk);
		start = 1'b0;
		req   = '0;
		while (done_count == done_base) begin
			@(negedge clk);
		end
		// Idle cycles that would expose a second done
		repeat (4) @(negedge clk);
		check_value("done pulses", 1, done_count - done_base);
		check_value("ar handshakes", 1, ar_count - ar_base);
		check_value("ar payload", entry, ar_seen);
		// Later beats overwrite earlier ones
		for (int i = 0; i <= entry.len; i++) begin
			a = beat_tab[bi + i];
			for (int k = 0; k < nbytes; k++) begin
				model[a + 12'(k)] = 8'hA0 + {entry.id, 4'h0} + 8'(i) + 8'(k);
			end
		end
		// Each beat plus four bytes on either side
		for (int i = 0; i <= entry.len; i++) begin
			for (int off = -4; off < nbytes + 4; off++) begin
				ra = beat_tab[bi + i] + 12'(off);
				mem_raddr = ra;
				@(negedge clk);
				check_value($sformatf("mem[%03h]", ra), model[ra], mem_rdata);
			end
		end
		$display("test %0d burst %0d size %0d len %0d: %0s", t, entry.burst, entry.size,
			entry.len, (err_count == err_base) ? "ok" : "mismatch");
	endtask

	always @(posedge clk) begin
		if (resetn) begin
			if (done) begin
				done_count <= done_count + 1;
			end
			// busy spans the whole burst and clears together with done
			if (watch_busy) begin
				check_value("busy", !done, busy);
			end
			if (start && !busy) begin
				watch_busy <= 1'b1;
			end else if (done) begin
				watch_busy <= 1'b0;
			end
			if (ar_wait_q) begin
				check_value("arvalid", 1, arvalid);
				check_value("ar", ar_hold_q, ar);
			end
			ar_wait_q <= arvalid && !arready;
			ar_hold_q <= ar;
		end
	end

	initial begin
		#(LIMIT_CYCLES * 40);
		$display("Timeout: test %0d never reached done", cur_test);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int bi;
		clk         = 1'b0;
		resetn      = 1'b0;
		start       = 1'b0;
		req         = '0;
		mem_raddr   = '0;
		cur_test    = -1;
		check_count = 0;
		err_count   = 0;
		done_count  = 0;
		watch_busy  = 1'b0;
		ar_wait_q   = 1'b0;
		ar_hold_q   = '0;
		load_table();
		repeat (RESET_CYCLES) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		check_value("arvalid", 0, arvalid);
		check_value("rready", 0, rready);
		check_value("busy", 0, busy);
		check_value("done", 0, done);
		$display("reset: %0s", (err_count == 0) ? "ok" : "mismatch");
		bi = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_test = t;
			run_test(t, bi);
			bi += req_tab[t].len + 1;
		end
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, err_count);
		if (err_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/ar_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module ar_issue (
	input  logic                clk,
	input  logic                resetn,
	input  logic                start,
	input  axi_rd_pkg::ar_req_t req,
	output axi_rd_pkg::ar_req_t ar,
	output logic                arvalid,
	input  logic                arready,
	input  logic                beat_last_taken,
	output axi_rd_pkg::ar_req_t ctx,
	output logic                ctx_valid,
	output logic                busy
);

	import axi_rd_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_ADDR = 2'b01,
		ST_DATA = 2'b10
	} state_t;

	state_t  state;
	ar_req_t req_q;
	logic    drain_q;
	logic    start_ok;

	// A new request is taken only once the previous one has fully landed
	assign start_ok = start && !busy;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_ok) begin
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (arready) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (beat_last_taken) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Last beat still sits in the write pipe for one more cycle
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			drain_q <= 1'b0;
		end else begin
			drain_q <= beat_last_taken;
		end
	end

	// Request held stable for AR and for the whole data phase
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start_ok) begin
			req_q <= req;
		end
	end

	assign ar        = req_q;
	assign arvalid   = (state == ST_ADDR);
	assign ctx       = req_q;
	assign ctx_valid = (state == ST_DATA);
	assign busy      = (state != ST_IDLE) || drain_q;

endmodule

`default_nettype wire

/* rtl/axi_rd_params.svh */
`ifndef AXI_RD_PARAMS_SVH
`define AXI_RD_PARAMS_SVH

// AXI read channel field widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4

// Length field holds beats minus one for 1 to 16 beats
`define AXI_LEN_W 4
`define AXI_SIZE_W 3

// Local byte memory
`define RAM_BYTES 4096
`define RAM_ADDR_W 12

// Byte count carried with each beat of up to 4 bytes
`define WR_NBYTES_W 3

`endif

/* rtl/axi_rd_pkg.sv */
`default_nettype none

`include "axi_rd_params.svh"

package axi_rd_pkg;

	// Encodings as on ARBURST
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_t;

	// Read request, also used as the AR payload
	typedef struct packed {
		logic [`AXI_ID_W-1:0]   id;
		logic [`AXI_ADDR_W-1:0] addr;
		logic [`AXI_LEN_W-1:0]  len;
		logic [`AXI_SIZE_W-1:0] size;
		burst_t                 burst;
	} ar_req_t;

	// R channel payload
	typedef struct packed {
		logic [`AXI_ID_W-1:0]   id;
		logic [`AXI_DATA_W-1:0] data;
		logic                   last;
	} r_beat_t;

	// One beat on its way into the byte memory
	typedef struct packed {
		logic [`RAM_ADDR_W-1:0]  addr;
		logic [`AXI_DATA_W-1:0]  data;
		logic [`WR_NBYTES_W-1:0] nbytes;
		logic                    last;
	} byte_wr_t;

endpackage

`default_nettype wire

/* rtl/axi_read_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module axi_read_master (
	input  logic                   clk,
	input  logic                   resetn,

	// Request side
	input  logic                   start,
	input  axi_rd_pkg::ar_req_t    req,
	output logic                   busy,
	output logic                   done,

	// AXI read address channel
	output axi_rd_pkg::ar_req_t    ar,
	output logic                   arvalid,
	input  logic                   arready,

	// AXI read data channel
	input  logic                   rvalid,
	input  axi_rd_pkg::r_beat_t    r,
	output logic                   rready,

	// Memory inspection port
	input  logic [`RAM_ADDR_W-1:0] mem_raddr,
	output logic [7:0]             mem_rdata
);

	import axi_rd_pkg::*;

	ar_req_t  ctx;
	logic     ctx_valid;
	logic     beat_last_taken;
	byte_wr_t wr;
	logic     wr_valid;

	ar_issue u_ar_issue (
		.clk             (clk),
		.resetn          (resetn),
		.start           (start),
		.req             (req),
		.ar              (ar),
		.arvalid         (arvalid),
		.arready         (arready),
		.beat_last_taken (beat_last_taken),
		.ctx             (ctx),
		.ctx_valid       (ctx_valid),
		.busy            (busy)
	);

	beat_addr_gen u_beat_addr_gen (
		.clk             (clk),
		.resetn          (resetn),
		.ctx             (ctx),
		.ctx_valid       (ctx_valid),
		.rvalid          (rvalid),
		.r               (r),
		.rready          (rready),
		.beat_last_taken (beat_last_taken),
		.wr              (wr),
		.wr_valid        (wr_valid)
	);

	byte_ram u_byte_ram (
		.clk       (clk),
		.resetn    (resetn),
		.wr        (wr),
		.wr_valid  (wr_valid),
		.mem_raddr (mem_raddr),
		.mem_rdata (mem_rdata),
		.done      (done)
	);

endmodule

`default_nettype wire

/* rtl/beat_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module beat_addr_gen (
	input  logic                 clk,
	input  logic                 resetn,
	input  axi_rd_pkg::ar_req_t  ctx,
	input  logic                 ctx_valid,
	input  logic                 rvalid,
	input  axi_rd_pkg::r_beat_t  r,
	output logic                 rready,
	output logic                 beat_last_taken,
	output axi_rd_pkg::byte_wr_t wr,
	output logic                 wr_valid
);

	import axi_rd_pkg::*;

	logic                    accept;
	logic                    first;
	logic [`RAM_ADDR_W-1:0]  cur_addr;
	logic [`RAM_ADDR_W-1:0]  beat_addr;
	logic [`RAM_ADDR_W-1:0]  step;
	logic [`RAM_ADDR_W-1:0]  incr_addr;
	logic [`RAM_ADDR_W-1:0]  beats;
	logic [`RAM_ADDR_W-1:0]  wrap_mask;
	logic [`RAM_ADDR_W-1:0]  next_addr;
	logic [`WR_NBYTES_W-1:0] nbytes;
	byte_wr_t                wr_q;
	logic                    wr_valid_q;

	// Memory never stalls, so ready simply follows an open burst
	assign rready          = ctx_valid;
	assign accept          = rvalid && ctx_valid;
	assign beat_last_taken = accept && r.last;

	// Only the low address bits matter since the memory wraps at its size
	assign beat_addr = first ? ctx.addr[`RAM_ADDR_W-1:0] : cur_addr;

	assign step      = {{(`RAM_ADDR_W-1){1'b0}}, 1'b1} << ctx.size;
	assign incr_addr = beat_addr + step;
	assign nbytes    = {{(`WR_NBYTES_W-1){1'b0}}, 1'b1} << ctx.size;

	// Wrap window of (len+1)*size bytes is always a power of two
	assign beats     = {{(`RAM_ADDR_W-`AXI_LEN_W){1'b0}}, ctx.len} + 1'b1;
	assign wrap_mask = (beats << ctx.size) - 1'b1;

	always_comb begin
		case (ctx.burst)
			BURST_FIXED: next_addr = beat_addr;
			BURST_WRAP:  next_addr = (beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
			default:     next_addr = incr_addr;
		endcase
	end

	// First beat of the next burst starts from the context address
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			first <= 1'b1;
		end else if (accept) begin
			first <= r.last;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cur_addr <= next_addr;
		end
	end

	// Beat register toward the byte memory
	always_ff @(posedge clk) begin
		if (accept) begin
			wr_q.addr   <= beat_addr;
			wr_q.data   <= r.data;
			wr_q.nbytes <= nbytes;
			wr_q.last   <= r.last;
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_valid_q <= 1'b0;
		end else begin
			wr_valid_q <= accept;
		end
	end

	assign wr       = wr_q;
	assign wr_valid = wr_valid_q;

endmodule

`default_nettype wire

/* rtl/byte_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_params.svh"

module byte_ram (
	input  logic                   clk,
	input  logic                   resetn,
	input  axi_rd_pkg::byte_wr_t   wr,
	input  logic                   wr_valid,
	input  logic [`RAM_ADDR_W-1:0] mem_raddr,
	output logic [7:0]             mem_rdata,
	output logic                   done
);

	logic [7:0] mem [`RAM_BYTES];

	// Lane k lands at addr+k and the 12-bit sum wraps around the memory
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			for (int k = 0; k < `AXI_DATA_W/8; k++) begin
				if (k < wr.nbytes) begin
					mem[wr.addr + `RAM_ADDR_W'(k)] <= wr.data[8*k +: 8];
				end
			end
		end
	end

	// Registered read port for inspection
	always_ff @(posedge clk) begin
		mem_rdata <= mem[mem_raddr];
	end

	// Burst complete once its last beat is in memory
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			done <= 1'b0;
		end else begin
			done <= wr_valid && wr.last;
		end
	end

endmodule

`default_nettype wire
